// File: verilog/qamDemapPkg.sv
// shared widths, latencies and legal bits-per-symbol codes for the even QAM LLR demapper
`default_nettype none

package qamDemapPkg;

  // --------------------
  // constellation limits
  // --------------------

  // largest bits per symbol, one word
  localparam int BMAX      = 12;
  // largest bits per axis
  localparam int AXIS_BMAX = BMAX / 2;

  // --------------------
  // data widths
  // --------------------

  // signed input coordinate
  localparam int DAT_W  = 8;
  // signed output soft bit
  localparam int LLR_W  = 5;
  // one guard bit so thr - |t| never wraps
  localparam int FOLD_W = DAT_W + 1;
  // bits-per-symbol code
  localparam int QAM_W  = 4;

  // saturation bounds of one soft bit
  localparam int LLR_MAX = (2 ** (LLR_W - 1)) - 1;
  localparam int LLR_MIN = -(2 ** (LLR_W - 1));

  // --------------------
  // latency in enabled cycles
  // --------------------

  localparam int CORE_LAT = 6;
  // one extra register for the bit ordering
  localparam int TOP_LAT  = CORE_LAT + 1;

  // --------------------
  // legal qam codes
  // --------------------

  localparam logic [QAM_W-1:0] QAM_QPSK = 4'd2;
  localparam logic [QAM_W-1:0] QAM_16   = 4'd4;
  localparam logic [QAM_W-1:0] QAM_64   = 4'd6;
  localparam logic [QAM_W-1:0] QAM_256  = 4'd8;
  localparam logic [QAM_W-1:0] QAM_1024 = 4'd10;
  localparam logic [QAM_W-1:0] QAM_4096 = 4'd12;

  // true for the six square constellations only
  function automatic logic isLegalQam(input logic [QAM_W-1:0] qam);
    case (qam)
      QAM_QPSK, QAM_16, QAM_64, QAM_256, QAM_1024, QAM_4096: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: verilog/axisLlrCore.sv
// per-axis max-log soft-bit pipeline that folds one coordinate into six saturated LLRs
`default_nettype none
`timescale 1ns/1ps

module axisLlrCore
  import qamDemapPkg::*;
(
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  // sample side
  input  logic                     ival,
  input  logic                     isop,
  input  logic [QAM_W-1:0]         iqam,
  input  logic signed [DAT_W-1:0]  idat,
  // soft-bit side
  output logic                     oval,
  output logic                     osop,
  output logic [QAM_W-1:0]         oqam,
  output logic signed [LLR_W-1:0]  oLlr [AXIS_BMAX]
);

  // --------------------
  // helpers
  // --------------------

  // one fold step tk = 2^(m-k) - |t(k-1)|
  // threshold drops to zero once k passes m
  function automatic logic signed [FOLD_W-1:0] foldStep(
    input logic signed [FOLD_W-1:0] t,
    input logic [QAM_W-1:0]         qam,
    input int                       k
  );
    int                       m;
    logic signed [FOLD_W-1:0] thr;
    logic signed [FOLD_W-1:0] mag;
    m = int'(qam >> 1);
    if (m >= k) begin
      thr = FOLD_W'(1 << (m - k));
    end else begin
      thr = '0;
    end
    // |t0| can reach 2^(DAT_W-1) and the guard bit holds it
    mag = (t < 0) ? -t : t;
    return thr - mag;
  endfunction

  // clamp to the signed soft-bit range instead of wrapping
  function automatic logic signed [LLR_W-1:0] satLlr(input logic signed [FOLD_W-1:0] t);
    if (t > LLR_MAX) begin
      return LLR_W'(LLR_MAX);
    end else if (t < LLR_MIN) begin
      return LLR_W'(LLR_MIN);
    end
    return LLR_W'(t);
  endfunction

  // --------------------
  // control chain
  // --------------------

  // index 0 is stage 1
  logic [CORE_LAT-1:0] valSr;
  logic [CORE_LAT-1:0] sopSr;
  logic [QAM_W-1:0]    qamSr [CORE_LAT];

  // one valid bit per stage
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      valSr <= '0;
    end else if (iclkena) begin
      valSr <= {valSr[CORE_LAT-2:0], ival};
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sopSr    <= {sopSr[CORE_LAT-2:0], isop};
      qamSr[0] <= iqam;
      for (int i = 1; i < CORE_LAT; i++) begin
        qamSr[i] <= qamSr[i-1];
      end
    end
  end

  assign oval = valSr[CORE_LAT-1];
  assign osop = sopSr[CORE_LAT-1];
  assign oqam = qamSr[CORE_LAT-1];

  // --------------------
  // fold pipeline
  // --------------------

  // stage n holds t0 .. t(n-1) and older levels just ride along
  logic signed [FOLD_W-1:0] tS1;
  logic signed [FOLD_W-1:0] tS2 [2];
  logic signed [FOLD_W-1:0] tS3 [3];
  logic signed [FOLD_W-1:0] tS4 [4];
  logic signed [FOLD_W-1:0] tS5 [5];

  // one fold level added per stage
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // stage 1 takes the coordinate sign extended to fold width
      tS1 <= FOLD_W'(idat);

      // stage 2 does the first fold with the stage 1 qam
      tS2[0] <= tS1;
      tS2[1] <= foldStep(tS1, qamSr[0], 1);

      // stage 3
      for (int j = 0; j < 2; j++) begin
        tS3[j] <= tS2[j];
      end
      tS3[2] <= foldStep(tS2[1], qamSr[1], 2);

      // stage 4
      for (int j = 0; j < 3; j++) begin
        tS4[j] <= tS3[j];
      end
      tS4[3] <= foldStep(tS3[2], qamSr[2], 3);

      // stage 5
      for (int j = 0; j < 4; j++) begin
        tS5[j] <= tS4[j];
      end
      tS5[4] <= foldStep(tS4[3], qamSr[3], 4);
    end
  end

  // --------------------
  // last fold and saturation
  // --------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int j = 0; j < AXIS_BMAX - 1; j++) begin
        oLlr[j] <= satLlr(tS5[j]);
      end
      // t5 is folded and clamped in the same cycle
      oLlr[AXIS_BMAX-1] <= satLlr(foldStep(tS5[4], qamSr[4], 5));
    end
  end

  // --------------------
  // checks
  // --------------------

  // only square constellations may enter the pipeline
  aLegalQam : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival) |-> isLegalQam(iqam)
  ) else $error("illegal qam code %0d accepted", iqam);

endmodule

`default_nettype wire

// File: verilog/evenQamDemapper.sv
// even QAM LLR demapper top with two axis pipelines and a registered LSB-first bit ordering
`default_nettype none
`timescale 1ns/1ps

module evenQamDemapper
  import qamDemapPkg::*;
(
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  // complex sample in
  input  logic                     ival,
  input  logic                     isop,
  input  logic [QAM_W-1:0]         iqam,
  input  logic signed [DAT_W-1:0]  idatRe,
  input  logic signed [DAT_W-1:0]  idatIm,
  // soft bits out
  output logic                     oval,
  output logic                     osop,
  output logic [QAM_W-1:0]         oqam,
  output logic signed [LLR_W-1:0]  oLlr [BMAX]
);

  // --------------------
  // axis pipelines
  // --------------------

  logic                    coreVal;
  logic                    coreSop;
  logic [QAM_W-1:0]        coreQam;
  logic signed [LLR_W-1:0] llrRe [AXIS_BMAX];
  logic signed [LLR_W-1:0] llrIm [AXIS_BMAX];

  // real axis also carries the control
  axisLlrCore uCoreRe (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .iqam    (iqam),
    .idat    (idatRe),
    .oval    (coreVal),
    .osop    (coreSop),
    .oqam    (coreQam),
    .oLlr    (llrRe)
  );

  // imaginary control is identical and left open
  axisLlrCore uCoreIm (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .iqam    (iqam),
    .idat    (idatIm),
    .oval    (),
    .osop    (),
    .oqam    (),
    .oLlr    (llrIm)
  );

  // --------------------
  // bit ordering
  // --------------------

  // bits per axis of the sample leaving the cores
  logic [2:0]              axisBits;
  logic signed [LLR_W-1:0] llrMap [BMAX];

  always_comb begin
    case (coreQam)
      QAM_QPSK : axisBits = 3'd1;
      QAM_16   : axisBits = 3'd2;
      QAM_64   : axisBits = 3'd3;
      QAM_256  : axisBits = 3'd4;
      QAM_1024 : axisBits = 3'd5;
      // qam4096 and anything unknown keep the full mapping
      default  : axisBits = 3'(AXIS_BMAX);
    endcase
  end

  // least index is the first bit of the symbol
  always_comb begin
    // full mapping with im on top and re below and the first fold highest
    for (int j = 0; j < AXIS_BMAX; j++) begin
      llrMap[BMAX-1-j]      = llrIm[j];
      llrMap[AXIS_BMAX-1-j] = llrRe[j];
    end
    // smaller constellations overwrite only the low 2m entries
    for (int j = 0; j < AXIS_BMAX; j++) begin
      if (j < int'(axisBits)) begin
        llrMap[2*int'(axisBits)-1-j] = llrIm[j];
        llrMap[int'(axisBits)-1-j]   = llrRe[j];
      end
    end
  end

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= coreVal;
    end
  end

  // payload follows the enable only
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      osop <= coreSop;
      oqam <= coreQam;
      for (int i = 0; i < BMAX; i++) begin
        oLlr[i] <= llrMap[i];
      end
    end
  end

  // --------------------
  // checks
  // --------------------

  // qam carried through both pipeline levels must stay a square code
  aOutQamEven : assert property (
    @(posedge iclk) disable iff (ireset)
    oval |-> (oqam != '0 && !oqam[0])
  ) else $error("odd or zero qam code %0d on output", oqam);

endmodule

`default_nettype wire

// File: bench/demapModel.svh
// reference model for the even QAM demapper with fold rule, clamping, LSB-first order and xorshift
`ifndef DEMAP_MODEL_SVH
`define DEMAP_MODEL_SVH

// --------------------
// random source
// --------------------

// xorshift32 with the 13/17/5 shifts
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// legal code 2 .. 12 from a selector
function automatic int qamCode(input int sel);
  return 2 * ((sel % 6) + 1);
endfunction

// --------------------
// fold rule
// --------------------

// 2^(m-k) or zero once k passes m
function automatic int foldThreshold(input int m, input int k);
  if (m >= k) begin
    return 1 << (m - k);
  end
  return 0;
endfunction

// level k of one coordinate
// t0 is the coordinate itself
function automatic int foldLevel(input int coord, input int m, input int k);
  int t;
  int mag;
  t = coord;
  for (int i = 1; i <= k; i++) begin
    mag = (t < 0) ? -t : t;
    t   = foldThreshold(m, i) - mag;
  end
  return t;
endfunction

// clamp to the signed soft-bit range instead of wrapping
function automatic int clampLlr(input int t);
  int hi;
  int lo;
  hi = (1 << (LLR_W - 1)) - 1;
  lo = -(1 << (LLR_W - 1));
  if (t > hi) begin
    return hi;
  end
  if (t < lo) begin
    return lo;
  end
  return t;
endfunction

// --------------------
// output ordering
// --------------------

// soft bit expected at oLlr[idx] for one sample
function automatic int expectedEntry(input int re, input int im, input int qam, input int idx);
  int m;
  int j;
  bit useIm;
  m = qam / 2;
  if (idx < 2 * m) begin
    // low 2m entries with im above re
    if (idx >= m) begin
      useIm = 1'b1;
      j     = 2 * m - 1 - idx;
    end else begin
      useIm = 1'b0;
      j     = m - 1 - idx;
    end
  end else if (idx >= AXIS_BMAX) begin
    // default upper half
    useIm = 1'b1;
    j     = BMAX - 1 - idx;
  end else begin
    useIm = 1'b0;
    j     = AXIS_BMAX - 1 - idx;
  end
  return clampLlr(foldLevel(useIm ? im : re, m, j));
endfunction

`endif

// File: bench/tbEvenQamDemapper.sv
// testbench for the even QAM demapper that checks random bursts against a delayed reference model
`default_nettype none
`timescale 1ns/1ps

module tbEvenQamDemapper
  import qamDemapPkg::*;
();

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'h7240_4021;
  localparam int          BURST_GUARD  = 400;
  localparam int          DRAIN_LIMIT  = 8 * TOP_LAT;
  localparam int          FULL_POS     = (1 << (DAT_W - 1)) - 1;
  localparam int          FULL_NEG     = -(1 << (DAT_W - 1));

  logic                    iclk;
  logic                    ireset;
  logic                    iclkena;
  logic                    ival;
  logic                    isop;
  logic [QAM_W-1:0]        iqam;
  logic signed [DAT_W-1:0] idatRe;
  logic signed [DAT_W-1:0] idatIm;
  logic                    oval;
  logic                    osop;
  logic [QAM_W-1:0]        oqam;
  logic signed [LLR_W-1:0] oLlr [BMAX];

  int          valErrors;
  int          dataErrors;
  int          holdErrors;
  int          flowErrors;
  int          acceptedCount;
  int          emittedCount;
  logic [31:0] rngState;

  `include "demapModel.svh"

  evenQamDemapper u_dut (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isop    (isop),
    .iqam    (iqam),
    .idatRe  (idatRe),
    .idatIm  (idatIm),
    .oval    (oval),
    .osop    (osop),
    .oqam    (oqam),
    .oLlr    (oLlr)
  );

  always #(CLK_PERIOD / 2) iclk = ~iclk;

  // --------------------
  // expected-value delay line
  // --------------------

  // head at TOP_LAT-1 lines up with the DUT outputs
  logic [TOP_LAT-1:0]      expVal;
  logic [TOP_LAT-1:0]      expSop;
  logic [QAM_W-1:0]        expQam [TOP_LAT];
  logic signed [LLR_W-1:0] expLlr [TOP_LAT][BMAX];

  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      expVal        <= '0;
      acceptedCount <= 0;
      emittedCount  <= 0;
    end else if (iclkena) begin
      expVal    <= {expVal[TOP_LAT-2:0], ival};
      expSop    <= {expSop[TOP_LAT-2:0], isop};
      expQam[0] <= iqam;
      for (int i = 0; i < BMAX; i++) begin
        expLlr[0][i] <= LLR_W'(expectedEntry(int'(idatRe), int'(idatIm), int'(iqam), i));
      end
      for (int d = 1; d < TOP_LAT; d++) begin
        expQam[d] <= expQam[d-1];
        for (int i = 0; i < BMAX; i++) begin
          expLlr[d][i] <= expLlr[d-1][i];
        end
      end
      // consumer takes every enabled valid cycle
      if (ival) begin
        acceptedCount <= acceptedCount + 1;
      end
      if (oval) begin
        emittedCount <= emittedCount + 1;
      end
    end
  end

  // outputs and enable of the previous edge for the freeze checks
  logic                    lastEna;
  logic                    lastVal;
  logic                    lastSop;
  logic [QAM_W-1:0]        lastQam;
  logic signed [LLR_W-1:0] lastLlr [BMAX];

  always @(posedge iclk) begin
    lastEna <= iclkena;
    lastVal <= oval;
    lastSop <= osop;
    lastQam <= oqam;
    for (int i = 0; i < BMAX; i++) begin
      lastLlr[i] <= oLlr[i];
    end
  end

  // --------------------
  // checks
  // --------------------

  aResetLow : assert property (@(posedge iclk) ireset |-> !oval)
    else begin
      valErrors++;
      $display("** Error at %0t: oval expected 0 got %0b", $time, $sampled(oval));
    end

  aVal : assert property (@(posedge iclk) disable iff (ireset) oval == expVal[TOP_LAT-1])
    else begin
      valErrors++;
      $display("** Error at %0t: oval expected %0b got %0b",
               $time, $sampled(expVal[TOP_LAT-1]), $sampled(oval));
    end

  aSop : assert property (@(posedge iclk) disable iff (ireset)
                          oval |-> osop == expSop[TOP_LAT-1])
    else begin
      dataErrors++;
      $display("** Error at %0t: osop expected %0b got %0b",
               $time, $sampled(expSop[TOP_LAT-1]), $sampled(osop));
    end

  aQam : assert property (@(posedge iclk) disable iff (ireset)
                          oval |-> oqam == expQam[TOP_LAT-1])
    else begin
      dataErrors++;
      $display("** Error at %0t: oqam expected %0d got %0d",
               $time, $sampled(expQam[TOP_LAT-1]), $sampled(oqam));
    end

  // frozen pipeline keeps every output
  aHoldCtl : assert property (@(posedge iclk) disable iff (ireset)
                              !lastEna |->
                              (oval == lastVal && osop == lastSop && oqam == lastQam))
    else begin
      holdErrors++;
      $display("** Error at %0t: oval/osop/oqam expected %0b/%0b/%0d got %0b/%0b/%0d",
               $time, $sampled(lastVal), $sampled(lastSop), $sampled(lastQam),
               $sampled(oval), $sampled(osop), $sampled(oqam));
    end

  for (genvar gi = 0; gi < BMAX; gi++) begin : gLlrCheck
    aLlr : assert property (@(posedge iclk) disable iff (ireset)
                            oval |-> oLlr[gi] == expLlr[TOP_LAT-1][gi])
      else begin
        dataErrors++;
        $display("** Error at %0t: oLlr[%0d] expected %0d got %0d",
                 $time, gi, $sampled(expLlr[TOP_LAT-1][gi]), $sampled(oLlr[gi]));
      end

    aLlrHold : assert property (@(posedge iclk) disable iff (ireset)
                                !lastEna |-> oLlr[gi] == lastLlr[gi])
      else begin
        holdErrors++;
        $display("** Error at %0t: oLlr[%0d] expected %0d got %0d",
                 $time, gi, $sampled(lastLlr[gi]), $sampled(oLlr[gi]));
      end
  end

  // --------------------
  // stimulus
  // --------------------

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // lattice point plus a small offset or sometimes full scale
  function automatic int pickCoord(input int m);
    logic [31:0] r;
    int          n;
    int          pt;
    int          off;
    r = nextRand();
    if (r[2:0] == 3'd0) begin
      return r[3] ? FULL_POS : FULL_NEG;
    end
    n   = 1 << m;
    pt  = 2 * (int'(r[15:4]) % n) - (n - 1);
    off = (int'(r[18:16]) % 7) - 3;
    return pt + off;
  endfunction

  // one falling-edge drive that reports whether the next rising edge takes it
  task automatic driveCycle(input logic ena, input logic val, input logic sop,
                            input int qam, input int re, input int im, output logic taken);
    @(negedge iclk);
    iclkena = ena;
    ival    = val;
    isop    = sop;
    iqam    = QAM_W'(qam);
    idatRe  = DAT_W'(re);
    idatIm  = DAT_W'(im);
    @(posedge iclk);
    taken = ena && val;
  endtask

  // burst of one qam code with random enable and valid gaps
  task automatic sendBurst(input int qam, input int len, input int enaSixteenths);
    int          sent;
    int          guard;
    logic        taken;
    logic [31:0] r;
    sent  = 0;
    guard = 0;
    while (sent < len && guard < BURST_GUARD) begin
      r = nextRand();
      driveCycle(int'(r[3:0]) < enaSixteenths, r[5:4] != 2'b00, sent == 0, qam,
                 pickCoord(qam / 2), pickCoord(qam / 2), taken);
      if (taken) begin
        sent++;
      end
      guard++;
    end
    if (sent < len) begin
      flowErrors++;
      $display("burst of qam %0d stopped after %0d of %0d samples", qam, sent, len);
    end
  endtask

  // back to back samples with a new qam code every cycle
  task automatic sendMixed(input int len, input bit extremes);
    logic [31:0] r;
    logic        taken;
    int          qam;
    for (int n = 0; n < len; n++) begin
      r   = nextRand();
      qam = qamCode(int'(r[7:0]));
      if (extremes) begin
        driveCycle(1'b1, 1'b1, n == 0, qam, r[8] ? FULL_POS : FULL_NEG,
                   r[9] ? FULL_POS : FULL_NEG, taken);
      end else begin
        driveCycle(1'b1, 1'b1, n == 0, qam, pickCoord(qam / 2), pickCoord(qam / 2), taken);
      end
    end
  endtask

  // enable held low while new data toggles at the inputs
  task automatic stallRun(input int len);
    logic [31:0] r;
    logic        taken;
    for (int n = 0; n < len; n++) begin
      r = nextRand();
      driveCycle(1'b0, 1'b1, r[0], qamCode(int'(r[7:0])), pickCoord(6), pickCoord(6), taken);
    end
  endtask

  // idle until everything accepted has left
  task automatic drainPipeline();
    int guard;
    guard = 0;
    @(negedge iclk);
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    while (emittedCount != acceptedCount && guard < DRAIN_LIMIT) begin
      @(negedge iclk);
      guard++;
    end
    if (emittedCount != acceptedCount) begin
      flowErrors++;
      $display("pipeline did not drain, %0d samples accepted but %0d emitted",
               acceptedCount, emittedCount);
    end
  endtask

  initial begin
    logic taken;
    iclk       = 1'b0;
    ireset     = 1'b1;
    iclkena    = 1'b1;
    // valid stays high through reset and must not leak out
    ival       = 1'b1;
    isop       = 1'b0;
    iqam       = QAM_QPSK;
    idatRe     = '0;
    idatIm     = '0;
    valErrors  = 0;
    dataErrors = 0;
    holdErrors = 0;
    flowErrors = 0;
    rngState   = SEED;

    repeat (RESET_CYCLES) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    ival   = 1'b0;

    // idle after reset while oval stays low
    for (int n = 0; n < 4; n++) begin
      driveCycle(1'b1, 1'b0, 1'b0, 2, 0, 0, taken);
    end

    // one burst per constellation
    for (int sel = 0; sel < 6; sel++) begin
      sendBurst(qamCode(sel), 20, 12);
    end

    // several codes in flight and then freezes around full-scale data
    sendMixed(24, 1'b0);
    stallRun(6);
    sendMixed(12, 1'b1);
    stallRun(5);
    sendBurst(qamCode(4), 16, 5);
    sendMixed(12, 1'b1);
    drainPipeline();

    $display("errors: valid %0d, payload %0d, hold %0d, flow %0d, samples %0d",
             valErrors, dataErrors, holdErrors, flowErrors, emittedCount);
    if (valErrors + dataErrors + holdErrors + flowErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
verilog/qamDemapPkg.sv
verilog/axisLlrCore.sv
verilog/evenQamDemapper.sv
bench/tbEvenQamDemapper.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= tbEvenQamDemapper
FILELIST ?= list.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
PASS_MSG := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
